// File: common/cic_pkg.sv
package cic_pkg;  // widths, ratio and sample types of the CIC decimator

    localparam int in_width = 5;             // signed input sample bits

    localparam int decim_ratio = 256;        // one output per 256 inputs
    localparam int cnt_width   = 8;          // log2(decim_ratio)

    // growth for one stage with M = 1 is log2(R*M) = 8 bits, the same as
    // the counter width, so the block sum always fits in acc_width
    localparam int acc_width = in_width + cnt_width; // 13 bits

    // raw two's complement sample from the input stream
    typedef logic signed [in_width-1:0] sample_t;

    // accumulator, decimated value and comb output wrap modulo 2**13
    typedef logic signed [acc_width-1:0] acc_t;

    // position of the current sample inside its block (0..255)
    typedef logic [cnt_width-1:0] cnt_t;

endpackage

// File: rtl/cic_integrator.sv
`timescale 1ns/1ps

// integrator stage of the CIC
// adds every strobed sample into a wrapping accumulator

module cic_integrator
(
    input  logic             clk,
    input  logic             rst,

    input  logic             in_valid,   // one-cycle sample strobe
    input  cic_pkg::sample_t in_sample,  // signed input sample

    output logic             acc_valid,  // in_valid delayed by one cycle
    output cic_pkg::acc_t    acc_value   // running sum, includes the strobed sample
);

    cic_pkg::acc_t sample_ext;  // sample widened to accumulator width
    cic_pkg::acc_t acc_next;    // accumulator after this cycle

    // sign-extend by replicating the msb into the growth bits
    always_comb
    begin
        sample_ext = {{(cic_pkg::acc_width - cic_pkg::in_width){in_sample[cic_pkg::in_width-1]}},
                      in_sample};
    end

    // next value of the running sum
    always_comb
    begin
        acc_next = acc_value;                     // hold when idle
        if (in_valid)
        begin
            acc_next = acc_value + sample_ext;    // modulo 2**13, wrap is normal for a CIC
        end
    end

    // accumulator register
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            acc_value <= '0;                      // partial block is thrown away
        end
        else
        begin
            acc_value <= acc_next;
        end
    end

    // strobe follows the data by exactly one register
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            acc_valid <= 1'b0;
        end
        else
        begin
            acc_valid <= in_valid;                // acc_value already holds this sample
        end
    end

endmodule

// File: rtl/cic_decimator.sv
`timescale 1ns/1ps

// rate change of the CIC
// counts integrator updates and keeps every 256th accumulator value

module cic_decimator
(
    input  logic          clk,
    input  logic          rst,

    input  logic          acc_valid,   // integrator update strobe
    input  cic_pkg::acc_t acc_value,   // integrator running sum

    output logic          dec_valid,   // one pulse per full block
    output cic_pkg::acc_t dec_value    // integrator value at the end of the block
);

    localparam cic_pkg::cnt_t cnt_last = cic_pkg::cnt_t'(cic_pkg::decim_ratio - 1); // 255

    cic_pkg::cnt_t cnt;        // updates seen in the current block
    logic          cnt_wrap;   // this update closes the block

    // the 256th update of a block
    assign cnt_wrap = acc_valid && (cnt == cnt_last);

    // block position counter
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt <= '0;                     // restart the block on reset
        end
        else if (acc_valid)
        begin
            if (cnt_wrap)
            begin
                cnt <= '0;                 // next block starts
            end
            else
            begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // output strobe, one cycle after the closing update
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            dec_valid <= 1'b0;
        end
        else
        begin
            dec_valid <= cnt_wrap;
        end
    end

    // sampled integrator value, only read while dec_valid is high
    always_ff @(posedge clk)
    begin
        if (cnt_wrap)
        begin
            dec_value <= acc_value;        // sum up to and including sample 256
        end
    end

    // a block needs 256 updates, so two outputs can never be adjacent
    assert property (@(posedge clk) disable iff (rst)
        dec_valid |=> !dec_valid)
        else $error("cic_decimator: dec_valid high on two consecutive cycles");

endmodule

// File: rtl/cic_comb.sv
`timescale 1ns/1ps

module cic_comb  // out = current decimated value minus the one before it
(
    input  logic          clk,
    input  logic          rst,

    input  logic          dec_valid,   // one pulse per block
    input  cic_pkg::acc_t dec_value,   // integrator value at the end of the block

    output logic          out_valid,   // dec_valid delayed by one cycle
    output cic_pkg::acc_t out_data     // block sum
);

    cic_pkg::acc_t prev_value;   // decimated value of the previous block
    cic_pkg::acc_t diff;         // exact wrapped difference as the sum fits 13 bits

    // subtract with the delayed operand
    assign diff = dec_value - prev_value;

    // delay line of one decimated sample
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            prev_value <= '0;            // integrator restarts from 0 as well
        end
        else if (dec_valid)
        begin
            prev_value <= dec_value;
        end
    end

    // registered output value
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_data <= '0;
        end
        else if (dec_valid)
        begin
            out_data <= diff;            // held until the next block
        end
    end

    // output strobe
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= dec_valid;
        end
    end

    // each output equals the step that the delay line has just taken
    assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_data == prev_value - $past(prev_value))
        else $error("cic_comb: out_data does not match the step of the delay line");

endmodule

// File: rtl/cic_top.sv
`timescale 1ns/1ps

// one-stage CIC decimator, R = 256, M = 1
// integrator -> decimator -> comb, three cycles from last input to output

module cic_top
(
    input  logic             clk,
    input  logic             rst,

    input  logic             in_valid,    // sample strobe, no back-pressure
    input  cic_pkg::sample_t in_sample,   // 5-bit signed sample

    output logic             out_valid,   // one pulse per 256 samples
    output cic_pkg::acc_t    out_data     // 13-bit signed block sum
);

    logic          acc_valid;   // integrator to decimator
    cic_pkg::acc_t acc_value;
    logic          dec_valid;   // decimator to comb
    cic_pkg::acc_t dec_value;

    cic_integrator u_integrator
    (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .acc_valid (acc_valid),
        .acc_value (acc_value)
    );

    cic_decimator u_decimator
    (
        .clk       (clk),
        .rst       (rst),
        .acc_valid (acc_valid),
        .acc_value (acc_value),
        .dec_valid (dec_valid),
        .dec_value (dec_value)
    );

    cic_comb u_comb
    (
        .clk       (clk),
        .rst       (rst),
        .dec_valid (dec_valid),
        .dec_value (dec_value),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

// free running clock and power-on reset for the testbench

module tb_clock_gen
(
    output logic clk,
    output logic rst
);

    localparam int half_period = 20;  // 40 ns period
    localparam int reset_cycles = 5;

    initial
    begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // reset released on a falling edge, like every other tb input
    initial
    begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: tb/tb_cic_top.sv
`timescale 1ns/1ps

// directed tests for the one-stage CIC decimator

module tb_cic_top;

    localparam int timeout_cycles = 8000;  // ~10 blocks of up to 512 cycles plus margin
    localparam int wait_limit = 16;        // cycles allowed for out_valid after a block

    logic             clk;
    logic             por_rst;             // power-on reset from the clock module
    logic             test_rst;            // mid-block reset driven by a test
    logic             rst;
    logic             in_valid;
    cic_pkg::sample_t in_sample;
    logic             out_valid;
    cic_pkg::acc_t    out_data;

    cic_pkg::sample_t blk [cic_pkg::decim_ratio];  // samples of the block being sent
    int               test_errors;
    int               pass_count;
    int               fail_count;
    int               cycle_count;

    assign rst = por_rst | test_rst;

    tb_clock_gen u_clock_gen
    (
        .clk (clk),
        .rst (por_rst)
    );

    cic_top u_dut
    (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    task automatic compare_acc(input string name, input cic_pkg::acc_t expected,
                               input cic_pkg::acc_t actual);
        if (expected !== actual)
        begin
            $display("error: %s expected %0d actual %0d", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic compare_bit(input string name, input string what, input logic expected,
                               input logic actual);
        if (expected !== actual)
        begin
            $display("%s: %s did not hold (saw %b instead of %b)", name, what, actual, expected);
            test_errors++;
        end
    endtask

    // model sum straight from the samples, wrapped to the output width
    function automatic cic_pkg::acc_t block_sum();
        int total;
        total = 0;
        for (int i = 0; i < cic_pkg::decim_ratio; i++)
            total += int'(blk[i]);
        return cic_pkg::acc_t'(total);
    endfunction

    task automatic fill_const(input cic_pkg::sample_t value);
        for (int i = 0; i < cic_pkg::decim_ratio; i++)
            blk[i] = value;
    endtask

    task automatic fill_random();
        for (int i = 0; i < cic_pkg::decim_ratio; i++)
            blk[i] = cic_pkg::sample_t'($urandom_range(31, 0));  // full -16..15 range
    endtask

    // sends blk[0..count-1], optional idle gaps, out_valid watched before each strobe
    task automatic feed_samples(input int count, input int max_gap, output logic low_ok);
        int gap;
        low_ok = 1'b1;
        for (int i = 0; i < count; i++)
        begin
            @(negedge clk);
            if (out_valid) low_ok = 1'b0;
            in_valid = 1'b1;
            in_sample = blk[i];
            gap = (max_gap > 0 && i < count - 1) ? int'($urandom_range(max_gap, 0)) : 0;
            repeat (gap)
            begin
                @(negedge clk);
                if (out_valid) low_ok = 1'b0;
                in_valid = 1'b0;                       // idle cycle between strobes
            end
        end
    endtask

    // full block, then wait for the output pulse and check its shape
    task automatic play_block(input string name, input int max_gap,
                              output cic_pkg::acc_t got, output int latency);
        logic low_ok;
        logic seen;
        feed_samples(cic_pkg::decim_ratio, max_gap, low_ok);
        compare_bit(name, "out_valid low during the block", 1'b1, low_ok);
        latency = 0;
        seen = 1'b0;
        got = '0;
        while (!seen && latency < wait_limit)
        begin
            @(negedge clk);
            in_valid = 1'b0;
            latency++;
            if (out_valid) seen = 1'b1;                // counted from the last strobe
        end
        if (!seen)
        begin
            $display("%s: out_valid never came after the block", name);
            test_errors++;
        end
        else
        begin
            got = out_data;
            @(negedge clk);
            compare_bit(name, "out_valid one cycle wide", 1'b0, out_valid);
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0)
        begin
            $display("%s: ok", name);
            pass_count++;
        end
        else
        begin
            $display("%s: %0d checks failed", name, test_errors);
            fail_count++;
        end
        test_errors = 0;
    endtask

    task automatic test_constant();
        cic_pkg::acc_t got;
        int            lat;
        fill_const(cic_pkg::sample_t'(1));
        play_block("constant", 0, got, lat);
        compare_acc("constant", cic_pkg::acc_t'(256), got);
        fill_const(cic_pkg::sample_t'(0));
        play_block("constant", 0, got, lat);
        compare_acc("constant", cic_pkg::acc_t'(0), got);  // comb removes the first block
        finish_test("constant");
    endtask

    task automatic test_extremes();
        cic_pkg::acc_t got;
        int            lat;
        fill_const(cic_pkg::sample_t'(-16));
        play_block("extremes", 0, got, lat);
        compare_acc("extremes", cic_pkg::acc_t'(-4096), got);
        fill_const(cic_pkg::sample_t'(15));
        play_block("extremes", 0, got, lat);
        compare_acc("extremes", cic_pkg::acc_t'(3840), got);
        finish_test("extremes");
    endtask

    task automatic test_random_gaps();
        cic_pkg::acc_t got;
        cic_pkg::acc_t expected;
        int            lat;
        for (int b = 0; b < 3; b++)
        begin
            fill_random();
            expected = block_sum();
            play_block("random_gaps", 1, got, lat);  // gap of 0 or 1 idle cycle
            compare_acc("random_gaps", expected, got);
        end
        finish_test("random_gaps");
    endtask

    task automatic test_latency();
        cic_pkg::acc_t got;
        int            lat;
        fill_random();
        play_block("latency", 0, got, lat);
        compare_bit("latency", "out_valid 3 cycles after the last strobe", 1'b1, lat == 3);
        compare_acc("latency", block_sum(), got);
        finish_test("latency");
    endtask

    task automatic test_mid_reset();
        cic_pkg::acc_t got;
        int            lat;
        logic          low_ok;
        fill_random();
        feed_samples(100, 0, low_ok);               // partial block, later discarded
        compare_bit("mid_reset", "out_valid low before the reset", 1'b1, low_ok);
        @(negedge clk);
        in_valid = 1'b0;
        test_rst = 1'b1;
        repeat (2) @(negedge clk);
        test_rst = 1'b0;
        repeat (4)
        begin
            @(negedge clk);
            compare_bit("mid_reset", "out_valid low after the reset", 1'b0, out_valid);
        end
        fill_random();
        play_block("mid_reset", 0, got, lat);
        compare_acc("mid_reset", block_sum(), got);
        finish_test("mid_reset");
    endtask

    // run limit, counted in clock cycles
    initial
    begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        in_valid = 1'b0;
        in_sample = '0;
        test_rst = 1'b0;
        test_errors = 0;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(32'h1da2bc29));
        @(negedge clk);
        while (por_rst) @(negedge clk);
        test_constant();
        test_extremes();
        test_random_gaps();
        test_latency();
        test_mid_reset();
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: flist.f
common/cic_pkg.sv
rtl/cic_integrator.sv
rtl/cic_decimator.sv
rtl/cic_comb.sv
rtl/cic_top.sv
tb/tb_clock_gen.sv
tb/tb_cic_top.sv

// File: Makefile
# Verilator build and run of the CIC decimator testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_cic_top -f flist.f -o sim_cic
	./obj_dir/sim_cic | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
